// File: logic/detect_pkg.sv
package detect_pkg;

	localparam int COORD_W = 12; // Pixel coordinate width
	localparam int LEVEL_W = 5;  // Up to 32 resize levels
	localparam int WORD_W  = 12; // FIFO and readout word

	// Words per stored record in the order x, y, level
	localparam int REC_WORDS = 3;

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [LEVEL_W-1:0] level_t;
	typedef logic [WORD_W-1:0]  word_t;

	// Window origin plus the resize level it was found at
	typedef struct packed {
		coord_t x;
		coord_t y;
		level_t level;
	} result_rec_t;

endpackage

// File: logic/step_counter.sv
module step_counter
#(
	parameter int WIDTH = 2
)
(
	input  logic             clk,
	input  logic             reset,
	input  logic             i_enable,
	output logic [WIDTH-1:0] o_count,
	output logic             o_last
);

	// Final index of a record sequence
	localparam logic [WIDTH-1:0] LAST = WIDTH'(detect_pkg::REC_WORDS - 1);

	logic [WIDTH-1:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
		end
		else if (i_enable)
		begin
			if (count == LAST)
				count <= '0; // Wrap for next record
			else
				count <= count + 1'b1;
		end
	end

	assign o_count = count;
	assign o_last  = (count == LAST);

endmodule

// File: logic/result_fifo.sv
module result_fifo
#(
	parameter int ADDR_WIDTH = 4
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_wr,
	input  detect_pkg::word_t     i_wr_data,
	input  logic                  i_rd,
	output detect_pkg::word_t     o_rd_data,
	output logic [ADDR_WIDTH:0]   o_used
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	detect_pkg::word_t mem [DEPTH];
	detect_pkg::word_t rd_data;

	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic [ADDR_WIDTH:0]   used;

	// Storage and registered read word
	always_ff @(posedge clk)
	begin
		if (i_wr)
			mem[wr_ptr] <= i_wr_data;
		if (i_rd)
			rd_data <= mem[rd_ptr]; // Word appears the cycle after i_rd
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_wr, i_rd})
				2'b10:   used <= used + 1'b1;
				2'b01:   used <= used - 1'b1;
				default: used <= used; // Both or neither
			endcase
		end
	end

	assign o_rd_data = rd_data;
	assign o_used    = used;

	// Writer must check room before it commits a record
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		i_wr |-> (used != DEPTH[ADDR_WIDTH:0]));

	// Reader only starts on a complete stored record
	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		i_rd |-> (used != '0));

endmodule

// File: logic/window_scanner.sv
module window_scanner
#(
	parameter int IMG_WIDTH  = 64,
	parameter int IMG_HEIGHT = 48,
	parameter int WIN_SIZE   = 24,
	parameter int STEP       = 8,
	parameter int NUM_LEVELS = 2
)
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_advance,
	output detect_pkg::result_rec_t o_window,
	output logic                    o_scan_done
);

	// Distance from origin to the far edge of the next window
	localparam int SPAN = STEP + WIN_SIZE;

	detect_pkg::result_rec_t win;
	logic done;
	logic x_wrap;
	logic y_wrap;
	logic last_level;

	// Next step would push the window past the image edge
	assign x_wrap     = (int'(win.x) + SPAN) > IMG_WIDTH;
	assign y_wrap     = (int'(win.y) + SPAN) > IMG_HEIGHT;
	assign last_level = (win.level == detect_pkg::level_t'(NUM_LEVELS - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			win  <= '0;
			done <= 1'b0;
		end
		else if (i_advance && !done)
		begin
			if (!x_wrap)
			begin
				win.x <= win.x + detect_pkg::coord_t'(STEP);
			end
			else if (!y_wrap)
			begin
				win.x <= '0;
				win.y <= win.y + detect_pkg::coord_t'(STEP); // Next row
			end
			else if (!last_level)
			begin
				win.x     <= '0;
				win.y     <= '0;
				win.level <= win.level + 1'b1; // Next resize level
			end
			else
			begin
				// Position stays put on the last window of the last level
				done <= 1'b1;
			end
		end
	end

	assign o_window    = win;
	assign o_scan_done = done;

	// Strobes are gated upstream once the scan is finished
	a_no_advance_after_done: assert property (@(posedge clk) disable iff (reset)
		done |-> !i_advance);

endmodule

// File: logic/detection_result.sv
module detection_result
#(
	parameter int FIFO_DEPTH = 16
)
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         i_window_done,
	input  logic                         i_hit,
	input  detect_pkg::result_rec_t      i_window,
	input  logic                         i_read,
	input  logic [$clog2(FIFO_DEPTH):0]  i_used,
	input  detect_pkg::word_t            i_rd_data,
	output logic                         o_ready,
	output logic                         o_advance,
	output logic                         o_wr,
	output detect_pkg::word_t            o_wr_data,
	output logic                         o_rd,
	output detect_pkg::word_t            o_data,
	output logic                         o_data_valid,
	output logic                         o_record_end,
	output logic                         o_record_avail,
	output logic                         o_overflow
);

	localparam int IDX_W = $clog2(detect_pkg::REC_WORDS);

	typedef enum logic {WR_IDLE, WR_BUSY} wr_state_t;
	typedef enum logic {RD_IDLE, RD_BUSY} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;

	detect_pkg::result_rec_t rec; // Captured hit window
	logic [IDX_W-1:0] wr_idx;
	logic wr_last;
	logic rd_last;
	logic accept;
	logic room;
	logic rd_start;
	logic wr_done;
	logic data_valid;
	logic record_end;
	logic overflow;
	logic [$clog2(FIFO_DEPTH):0] rec_count; // Complete records in FIFO

	assign o_ready  = (wr_state == WR_IDLE);
	assign accept   = i_window_done && o_ready;
	assign room     = (int'(i_used) + detect_pkg::REC_WORDS) <= FIFO_DEPTH;
	assign wr_done  = (wr_state == WR_BUSY) && wr_last;
	assign rd_start = (rd_state == RD_IDLE) && i_read && o_record_avail;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_state <= WR_IDLE;
			overflow <= 1'b0;
		end
		else if (accept && i_hit)
		begin
			if (room)
				wr_state <= WR_BUSY;
			else
				overflow <= 1'b1; // Record dropped and the flag stays set
		end
		else if (wr_done)
		begin
			wr_state <= WR_IDLE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && i_hit && room)
			rec <= i_window;
	end

	// Word order x, y, level
	always_comb
	begin
		case (wr_idx)
			0:       o_wr_data = rec.x;
			1:       o_wr_data = rec.y;
			default: o_wr_data = detect_pkg::word_t'(rec.level);
		endcase
	end

	step_counter #(.WIDTH(IDX_W)) u_wr_counter
	(
		.clk      (clk),
		.reset    (reset),
		.i_enable (o_wr),
		.o_count  (wr_idx),
		.o_last   (wr_last)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_state   <= RD_IDLE;
			data_valid <= 1'b0;
			record_end <= 1'b0;
		end
		else
		begin
			if (rd_start)
				rd_state <= RD_BUSY;
			else if (rd_last)
				rd_state <= RD_IDLE;
			data_valid <= o_rd;
			record_end <= o_rd && rd_last; // Third word read
		end
	end

	step_counter #(.WIDTH(IDX_W)) u_rd_counter
	(
		.clk      (clk),
		.reset    (reset),
		.i_enable (o_rd),
		.o_count  (),
		.o_last   (rd_last)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			rec_count <= '0;
		else if (wr_done && !rd_start)
			rec_count <= rec_count + 1'b1;
		else if (rd_start && !wr_done)
			rec_count <= rec_count - 1'b1;
	end

	assign o_advance      = accept;
	assign o_wr           = (wr_state == WR_BUSY);
	assign o_rd           = rd_start || (rd_state == RD_BUSY);
	assign o_data         = i_rd_data;
	assign o_data_valid   = data_valid;
	assign o_record_end   = record_end;
	assign o_record_avail = (rec_count != '0);
	assign o_overflow     = overflow;

	// Room was checked at capture, so every word of a record fits
	a_wr_has_room: assert property (@(posedge clk) disable iff (reset)
		o_wr |-> (int'(i_used) < FIFO_DEPTH));

endmodule

// File: logic/detection_result_top.sv
module detection_result_top
#(
	parameter int IMG_WIDTH       = 64,
	parameter int IMG_HEIGHT      = 48,
	parameter int WIN_SIZE        = 24,
	parameter int STEP            = 8,
	parameter int NUM_LEVELS      = 2,
	parameter int FIFO_ADDR_WIDTH = 4
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              i_window_done,
	input  logic              i_hit,
	input  logic              i_read,
	output logic              o_ready,
	output logic              o_scan_done,
	output detect_pkg::word_t o_data,
	output logic              o_data_valid,
	output logic              o_record_end,
	output logic              o_record_avail,
	output logic              o_overflow
);

	localparam int FIFO_DEPTH = 1 << FIFO_ADDR_WIDTH;

	detect_pkg::result_rec_t window;
	detect_pkg::word_t fifo_wr_data;
	detect_pkg::word_t fifo_rd_data;
	logic [FIFO_ADDR_WIDTH:0] fifo_used;
	logic fifo_wr;
	logic fifo_rd;
	logic advance;
	logic scan_done;
	logic window_done_live;

	// No strobe is accepted once the scan is over
	assign window_done_live = i_window_done && !scan_done;

	window_scanner
	#(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT),
		.WIN_SIZE   (WIN_SIZE),
		.STEP       (STEP),
		.NUM_LEVELS (NUM_LEVELS)
	)
	u_scanner
	(
		.clk         (clk),
		.reset       (reset),
		.i_advance   (advance),
		.o_window    (window),
		.o_scan_done (scan_done)
	);

	detection_result #(.FIFO_DEPTH(FIFO_DEPTH)) u_result
	(
		.clk            (clk),
		.reset          (reset),
		.i_window_done  (window_done_live),
		.i_hit          (i_hit),
		.i_window       (window),
		.i_read         (i_read),
		.i_used         (fifo_used),
		.i_rd_data      (fifo_rd_data),
		.o_ready        (o_ready),
		.o_advance      (advance),
		.o_wr           (fifo_wr),
		.o_wr_data      (fifo_wr_data),
		.o_rd           (fifo_rd),
		.o_data         (o_data),
		.o_data_valid   (o_data_valid),
		.o_record_end   (o_record_end),
		.o_record_avail (o_record_avail),
		.o_overflow     (o_overflow)
	);

	result_fifo #(.ADDR_WIDTH(FIFO_ADDR_WIDTH)) u_fifo
	(
		.clk       (clk),
		.reset     (reset),
		.i_wr      (fifo_wr),
		.i_wr_data (fifo_wr_data),
		.i_rd      (fifo_rd),
		.o_rd_data (fifo_rd_data),
		.o_used    (fifo_used)
	);

	assign o_scan_done = scan_done;

endmodule

// File: tests/detection_result_tb.sv
module detection_result_tb;

	localparam int IMG_WIDTH       = 64;
	localparam int IMG_HEIGHT      = 48;
	localparam int WIN_SIZE        = 24;
	localparam int STEP            = 8;
	localparam int NUM_LEVELS      = 2;
	localparam int FIFO_ADDR_WIDTH = 4;
	localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;
	localparam int NUM_ROWS        = 18;

	typedef enum logic {OP_STEP, OP_READ} op_t;

	// One table row
	// exp_count is records stored by steps or records read back
	typedef struct packed {
		op_t  op;
		logic hit;
		int   reps;
		int   exp_count;
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{OP_STEP, 1'b1, 1, 1},  // First window hits
		'{OP_STEP, 1'b0, 2, 0},
		'{OP_READ, 1'b0, 1, 1},
		'{OP_READ, 1'b0, 1, 0},  // Strobe ignored with nothing stored
		'{OP_STEP, 1'b1, 1, 1},
		'{OP_STEP, 1'b0, 1, 0},
		'{OP_STEP, 1'b1, 1, 1},
		'{OP_READ, 1'b0, 1, 1},  // Reads and hits interleaved
		'{OP_STEP, 1'b1, 1, 1},
		'{OP_READ, 1'b0, 2, 2},
		'{OP_STEP, 1'b1, 6, 5},  // Sixth record overflows
		'{OP_READ, 1'b0, 6, 5},
		'{OP_STEP, 1'b0, 20, 0}, // Into level 1
		'{OP_STEP, 1'b1, 1, 1},
		'{OP_READ, 1'b0, 1, 1},
		'{OP_STEP, 1'b0, 14, 0}, // Last window of last level
		'{OP_STEP, 1'b1, 3, 0},  // Strobes do nothing after the scan
		'{OP_READ, 1'b0, 1, 0}
	};

	logic clk;
	logic reset;
	logic i_window_done;
	logic i_hit;
	logic i_read;
	logic o_ready;
	logic o_scan_done;
	detect_pkg::word_t o_data;
	logic o_data_valid;
	logic o_record_end;
	logic o_record_avail;
	logic o_overflow;

	// Reference model of the scan grid
	int m_x;
	int m_y;
	int m_level;
	bit m_done;
	bit m_overflow;
	detect_pkg::result_rec_t exp_q [$];

	int errors;
	int checks;
	int row_errors;
	int cycles;
	int cycle_limit;

	detection_result_top
	#(
		.IMG_WIDTH       (IMG_WIDTH),
		.IMG_HEIGHT      (IMG_HEIGHT),
		.WIN_SIZE        (WIN_SIZE),
		.STEP            (STEP),
		.NUM_LEVELS      (NUM_LEVELS),
		.FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
	)
	uut
	(
		.clk            (clk),
		.reset          (reset),
		.i_window_done  (i_window_done),
		.i_hit          (i_hit),
		.i_read         (i_read),
		.o_ready        (o_ready),
		.o_scan_done    (o_scan_done),
		.o_data         (o_data),
		.o_data_valid   (o_data_valid),
		.o_record_end   (o_record_end),
		.o_record_avail (o_record_avail),
		.o_overflow     (o_overflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input int actual, input int expected);
		checks++;
		assert (actual == expected)
		else
		begin
			errors++;
			row_errors++;
			$display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			row_errors++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	// Scanner step rule with done after the last window of the last level
	task automatic advance_model();
		if (m_x + STEP + WIN_SIZE <= IMG_WIDTH)
			m_x += STEP;
		else if (m_y + STEP + WIN_SIZE <= IMG_HEIGHT)
		begin
			m_x = 0;
			m_y += STEP;
		end
		else if (m_level < NUM_LEVELS - 1)
		begin
			m_x = 0;
			m_y = 0;
			m_level++;
		end
		else
			m_done = 1'b1;
	endtask

	task automatic apply_window_step(input bit hit, inout int stored);
		detect_pkg::result_rec_t rec;
		int low_cycles;
		int expect_low;
		@(posedge clk);
		i_window_done <= 1'b1;
		i_hit         <= hit;
		@(posedge clk);
		i_window_done <= 1'b0;
		i_hit         <= 1'b0;
		expect_low = 0;
		if (!m_done)
		begin
			if (hit)
			begin
				if (exp_q.size() * detect_pkg::REC_WORDS + detect_pkg::REC_WORDS <= FIFO_DEPTH)
				begin
					rec.x     = detect_pkg::coord_t'(m_x);
					rec.y     = detect_pkg::coord_t'(m_y);
					rec.level = detect_pkg::level_t'(m_level);
					exp_q.push_back(rec);
					expect_low = 3; // One cycle per word
				end
				else
					m_overflow = 1'b1;
			end
			advance_model();
		end
		low_cycles = 0;
		@(negedge clk);
		while (!o_ready && low_cycles < 10)
		begin
			low_cycles++;
			@(negedge clk);
		end
		if (low_cycles == detect_pkg::REC_WORDS)
			stored++; // Record written by the DUT
		check_value("o_ready low cycles", low_cycles, expect_low);
		check_value("o_scan_done", o_scan_done, m_done);
		check_value("o_overflow", o_overflow, m_overflow);
		check_value("o_record_avail", o_record_avail, exp_q.size() != 0);
	endtask

	task automatic read_back_record(inout int taken);
		detect_pkg::result_rec_t rec;
		int words;
		int wait_cycles;
		int expected_word;
		check_value("o_record_avail", o_record_avail, exp_q.size() != 0);
		@(posedge clk);
		i_read <= 1'b1;
		@(posedge clk);
		i_read <= 1'b0;
		if (exp_q.size() == 0)
		begin
			repeat (5)
			begin
				@(negedge clk);
				check_true(!o_data_valid, "data came out although no record was stored");
				if (o_record_end)
					taken++;
			end
		end
		else
		begin
			rec = exp_q.pop_front();
			words = 0;
			wait_cycles = 0;
			while (words < detect_pkg::REC_WORDS && wait_cycles < 10)
			begin
				@(negedge clk);
				wait_cycles++;
				if (o_data_valid)
				begin
					case (words)
						0:       expected_word = rec.x;
						1:       expected_word = rec.y;
						default: expected_word = rec.level;
					endcase
					check_value("o_data", o_data, expected_word);
					check_value("o_record_end", o_record_end, words == 2);
					if (o_record_end)
						taken++;
					words++;
				end
				else
					check_true(!o_record_end, "record end flagged without valid data");
			end
			check_true(words == detect_pkg::REC_WORDS, "readout stopped before three words");
			@(negedge clk);
			check_value("o_data_valid", o_data_valid, 0); // Exactly three words
		end
		check_value("o_record_avail", o_record_avail, exp_q.size() != 0);
	endtask

	initial
	begin
		int count;
		int total_ops;
		int passed;
		int failed;
		reset         = 1'b1;
		i_window_done = 1'b0;
		i_hit         = 1'b0;
		i_read        = 1'b0;
		m_x = 0;
		m_y = 0;
		m_level = 0;
		m_done = 1'b0;
		m_overflow = 1'b0;
		errors = 0;
		checks = 0;
		cycles = 0;
		passed = 0;
		failed = 0;
		total_ops = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total_ops += ROWS[r].reps;
		cycle_limit = 40 * total_ops + 20; // 40 cycles per operation plus reset

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		row_errors = 0;
		check_value("o_ready", o_ready, 1);
		check_value("o_data_valid", o_data_valid, 0);
		check_value("o_record_end", o_record_end, 0);
		check_value("o_overflow", o_overflow, 0);
		check_value("o_scan_done", o_scan_done, 0);
		check_value("o_record_avail", o_record_avail, 0);
		$display("Reset state: %0d errors", row_errors);
		if (row_errors == 0)
			passed++;
		else
			failed++;

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			row_errors = 0;
			count = 0;
			for (int k = 0; k < ROWS[r].reps; k++)
			begin
				if (ROWS[r].op == OP_STEP)
					apply_window_step(ROWS[r].hit, count);
				else
					read_back_record(count);
			end
			check_value("records in row", count, ROWS[r].exp_count);
			$display("Row %2d %s hit=%0d x%0d: %0d errors", r,
				(ROWS[r].op == OP_STEP) ? "step" : "read", ROWS[r].hit, ROWS[r].reps, row_errors);
			if (row_errors == 0)
				passed++;
			else
				failed++;
		end

		$display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
			passed, failed, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: detection_result_top.f
logic/detect_pkg.sv
logic/step_counter.sv
logic/result_fifo.sv
logic/window_scanner.sv
logic/detection_result.sv
logic/detection_result_top.sv
tests/detection_result_tb.sv

// File: Makefile
TOP := detection_result_tb
LOG := sim.log

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f detection_result_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean
